//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_pipe_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only if the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/alu_pipe_pkg.sv
`default_nettype none

package alu_pipe_pkg;

    // widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 3;
    localparam int OP_W       = 3;

    // register file and pipeline depth
    localparam int NUM_REGS    = 8;
    localparam int NUM_SLOTS   = 3;
    localparam int NUM_TRACKED = NUM_SLOTS + 1;  // slots plus writeback

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OP_W-1:0]       op_t;

    // opcodes, 6 and 7 fall back to load-immediate
    localparam op_t OP_LI  = 3'd0;
    localparam op_t OP_ADD = 3'd1;
    localparam op_t OP_SUB = 3'd2;
    localparam op_t OP_AND = 3'd3;
    localparam op_t OP_OR  = 3'd4;
    localparam op_t OP_XOR = 3'd5;

endpackage

`default_nettype wire

//--- design/alu_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_top (
    input  logic                    clk_i,
    input  logic                    locked_i,
    input  logic                    instr_valid_i,
    output logic                    instr_ready_o,
    input  alu_pipe_pkg::op_t       instr_op_i,
    input  alu_pipe_pkg::reg_addr_t instr_rd_i,
    input  alu_pipe_pkg::reg_addr_t instr_rs1_i,
    input  alu_pipe_pkg::reg_addr_t instr_rs2_i,
    input  alu_pipe_pkg::data_t     instr_imm_i,
    output logic                    commit_valid_o,
    input  logic                    commit_ready_i,
    output alu_pipe_pkg::reg_addr_t commit_dest_o,
    output alu_pipe_pkg::data_t     commit_data_o
);

    alu_pipe_pkg::reg_addr_t rs1_addr, rs2_addr;
    alu_pipe_pkg::data_t     rs1_data, rs2_data;
    logic                    rf_we;
    alu_pipe_pkg::reg_addr_t rf_waddr;
    alu_pipe_pkg::data_t     rf_wdata;

    // slot contents plus the writeback entry
    logic [alu_pipe_pkg::NUM_TRACKED-1:0] inflight_valid;
    alu_pipe_pkg::reg_addr_t              inflight_dest [alu_pipe_pkg::NUM_TRACKED];

    stage_link_if link [0:alu_pipe_pkg::NUM_SLOTS] ();

    issue_stage u_issue (
        .clk_i            (clk_i),
        .locked_i         (locked_i),
        .instr_valid_i    (instr_valid_i),
        .instr_ready_o    (instr_ready_o),
        .instr_op_i       (instr_op_i),
        .instr_rd_i       (instr_rd_i),
        .instr_rs1_i      (instr_rs1_i),
        .instr_rs2_i      (instr_rs2_i),
        .instr_imm_i      (instr_imm_i),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .inflight_valid_i (inflight_valid),
        .inflight_dest_i  (inflight_dest),
        .out              (link[0].up)
    );

    for (genvar g = 0; g < alu_pipe_pkg::NUM_SLOTS; g++) begin : g_slot
        pipe_slot u_slot (
            .clk_i    (clk_i),
            .locked_i (locked_i),
            .in       (link[g].down),
            .out      (link[g+1].up)
        );

        assign inflight_valid[g] = link[g+1].valid;  // slot g holds an entry
        assign inflight_dest[g]  = link[g+1].dest;
    end

    assign inflight_valid[alu_pipe_pkg::NUM_SLOTS] = commit_valid_o;
    assign inflight_dest[alu_pipe_pkg::NUM_SLOTS]  = commit_dest_o;

    writeback_stage u_wb (
        .clk_i          (clk_i),
        .locked_i       (locked_i),
        .in             (link[alu_pipe_pkg::NUM_SLOTS].down),
        .commit_ready_i (commit_ready_i),
        .commit_valid_o (commit_valid_o),
        .commit_dest_o  (commit_dest_o),
        .commit_data_o  (commit_data_o),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata)
    );

    reg_file u_rf (
        .clk_i    (clk_i),
        .locked_i (locked_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

endmodule

`default_nettype wire

//--- design/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                    clk_i,
    input  logic                    locked_i,
    input  logic                    instr_valid_i,
    output logic                    instr_ready_o,
    input  alu_pipe_pkg::op_t       instr_op_i,
    input  alu_pipe_pkg::reg_addr_t instr_rd_i,
    input  alu_pipe_pkg::reg_addr_t instr_rs1_i,
    input  alu_pipe_pkg::reg_addr_t instr_rs2_i,
    input  alu_pipe_pkg::data_t     instr_imm_i,
    output alu_pipe_pkg::reg_addr_t rs1_addr_o,
    output alu_pipe_pkg::reg_addr_t rs2_addr_o,
    input  alu_pipe_pkg::data_t     rs1_data_i,
    input  alu_pipe_pkg::data_t     rs2_data_i,
    input  logic [alu_pipe_pkg::NUM_TRACKED-1:0] inflight_valid_i,
    input  alu_pipe_pkg::reg_addr_t inflight_dest_i [alu_pipe_pkg::NUM_TRACKED],
    stage_link_if.up                out
);

    logic                    uses_rs;
    logic                    hazard;
    logic                    accept;
    logic                    valid_q;
    alu_pipe_pkg::reg_addr_t dest_q;
    alu_pipe_pkg::data_t     data_q;
    alu_pipe_pkg::data_t     alu_res;

    assign rs1_addr_o = instr_rs1_i;
    assign rs2_addr_o = instr_rs2_i;

    // decode and ALU
    always_comb begin
        uses_rs = 1'b1;
        case (instr_op_i)
            alu_pipe_pkg::OP_ADD: alu_res = rs1_data_i + rs2_data_i;
            alu_pipe_pkg::OP_SUB: alu_res = rs1_data_i - rs2_data_i;
            alu_pipe_pkg::OP_AND: alu_res = rs1_data_i & rs2_data_i;
            alu_pipe_pkg::OP_OR:  alu_res = rs1_data_i | rs2_data_i;
            alu_pipe_pkg::OP_XOR: alu_res = rs1_data_i ^ rs2_data_i;
            alu_pipe_pkg::OP_LI: begin
                uses_rs = 1'b0;
                alu_res = instr_imm_i;
            end
            default: begin  // unused codes act as LI
                uses_rs = 1'b0;
                alu_res = instr_imm_i;
            end
        endcase
    end

    // RAW check, own output register counts as in flight too
    always_comb begin
        hazard = valid_q && (dest_q == instr_rs1_i || dest_q == instr_rs2_i);
        for (int i = 0; i < alu_pipe_pkg::NUM_TRACKED; i++) begin
            if (inflight_valid_i[i] && (inflight_dest_i[i] == instr_rs1_i ||
                                        inflight_dest_i[i] == instr_rs2_i))
                hazard = 1'b1;
        end
        hazard = hazard & uses_rs;
    end

    assign instr_ready_o = ~hazard & (~valid_q | out.allow_in);
    assign accept        = instr_valid_i & instr_ready_o;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out.allow_in) begin
            valid_q <= 1'b0;  // drained into slot 0
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dest_q <= instr_rd_i;
            data_q <= alu_res;
        end
    end

    assign out.valid = valid_q;
    assign out.dest  = dest_q;
    assign out.data  = data_q;

endmodule

`default_nettype wire

//--- design/pipe_slot.sv
`timescale 1ns/1ps
`default_nettype none

// single holding slot, passes one result per handshake
module pipe_slot (
    input  logic       clk_i,
    input  logic       locked_i,
    stage_link_if.down in,
    stage_link_if.up   out
);

    logic                    full_q;
    logic                    load;
    alu_pipe_pkg::reg_addr_t dest_q;
    alu_pipe_pkg::data_t     data_q;

    // empty, or emptying this cycle
    assign in.allow_in = ~full_q | out.allow_in;
    assign load        = in.valid & in.allow_in;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            full_q <= 1'b0;
        end else if (in.allow_in) begin
            full_q <= in.valid;  // refill or drain
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            dest_q <= in.dest;
            data_q <= in.data;
        end
    end

    assign out.valid = full_q;
    assign out.dest  = dest_q;
    assign out.data  = data_q;

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                    clk_i,
    input  logic                    locked_i,
    input  alu_pipe_pkg::reg_addr_t raddr1_i,
    input  alu_pipe_pkg::reg_addr_t raddr2_i,
    output alu_pipe_pkg::data_t     rdata1_o,
    output alu_pipe_pkg::data_t     rdata2_o,
    input  logic                    we_i,
    input  alu_pipe_pkg::reg_addr_t waddr_i,
    input  alu_pipe_pkg::data_t     wdata_i
);

    alu_pipe_pkg::data_t regs_q [alu_pipe_pkg::NUM_REGS];

    // all registers read zero after reset, r0 included
    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            for (int i = 0; i < alu_pipe_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // no bypass, same-cycle read returns old value
    assign rdata1_o = regs_q[raddr1_i];
    assign rdata2_o = regs_q[raddr2_i];

endmodule

`default_nettype wire

//--- design/stage_link_if.sv
`timescale 1ns/1ps
`default_nettype none

// one hop between adjacent stages
interface stage_link_if;

    logic                    valid;     // upstream holds an entry
    logic                    allow_in;  // downstream can take it this cycle
    alu_pipe_pkg::reg_addr_t dest;
    alu_pipe_pkg::data_t     data;

    modport up (
        output valid, dest, data,
        input  allow_in
    );

    modport down (
        input  valid, dest, data,
        output allow_in
    );

endinterface

`default_nettype wire

//--- design/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                    clk_i,
    input  logic                    locked_i,
    stage_link_if.down              in,
    input  logic                    commit_ready_i,
    output logic                    commit_valid_o,
    output alu_pipe_pkg::reg_addr_t commit_dest_o,
    output alu_pipe_pkg::data_t     commit_data_o,
    output logic                    rf_we_o,
    output alu_pipe_pkg::reg_addr_t rf_waddr_o,
    output alu_pipe_pkg::data_t     rf_wdata_o
);

    logic                    full_q;
    logic                    commit;
    alu_pipe_pkg::reg_addr_t dest_q;
    alu_pipe_pkg::data_t     data_q;

    assign commit      = full_q & commit_ready_i;
    assign in.allow_in = ~full_q | commit_ready_i;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            full_q <= 1'b0;
        end else if (in.allow_in) begin
            full_q <= in.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in.valid && in.allow_in) begin
            dest_q <= in.dest;
            data_q <= in.data;
        end
    end

    assign commit_valid_o = full_q;
    assign commit_dest_o  = dest_q;
    assign commit_data_o  = data_q;

    // register write lands on the commit edge
    assign rf_we_o    = commit;
    assign rf_waddr_o = dest_q;
    assign rf_wdata_o = data_q;

endmodule

`default_nettype wire

//--- project.f
design/alu_pipe_pkg.sv
design/stage_link_if.sv
design/reg_file.sv
design/issue_stage.sv
design/pipe_slot.sv
design/writeback_stage.sv
design/alu_pipe_top.sv
tb/clock_gen.sv
tb/alu_pipe_checker.sv
tb/alu_pipe_tb.sv

//--- tb/alu_pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

// handshake and reset rules seen at the top-level ports
module alu_pipe_checker (
    input logic                    clk_i,
    input logic                    locked_i,
    input logic                    instr_ready_i,
    input logic                    commit_valid_i,
    input logic                    commit_ready_i,
    input alu_pipe_pkg::reg_addr_t commit_dest_i,
    input alu_pipe_pkg::data_t     commit_data_i
);

    // a stalled commit offer stays up and unchanged
    property commit_held_p;
        @(posedge clk_i) disable iff (!locked_i)
            commit_valid_i && !commit_ready_i |=>
                commit_valid_i && $stable(commit_dest_i) && $stable(commit_data_i);
    endproperty

    a_commit_held: assert property (commit_held_p)
        else $error("commit offer dropped or changed while commit_ready was low");

    a_idle_in_reset: assert property (
        @(posedge clk_i) !locked_i && $past(!locked_i) |-> !commit_valid_i)
        else $error("commit_valid high while the design is held in reset");

    a_ready_known: assert property (
        @(posedge clk_i) disable iff (!locked_i) !$isunknown(instr_ready_i))
        else $error("instr_ready is unknown after reset");

endmodule

`default_nettype wire

//--- tb/alu_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_tb;

    localparam int NUM_ROWS = 24;
    // each row may sit out a full pipe several times under random back-pressure
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (alu_pipe_pkg::NUM_SLOTS + 2) * 8;

    logic                    clk;
    logic                    locked;
    logic                    instr_valid;
    logic                    instr_ready;
    alu_pipe_pkg::op_t       instr_op;
    alu_pipe_pkg::reg_addr_t instr_rd;
    alu_pipe_pkg::reg_addr_t instr_rs1;
    alu_pipe_pkg::reg_addr_t instr_rs2;
    alu_pipe_pkg::data_t     instr_imm;
    logic                    commit_valid;
    logic                    commit_ready;
    alu_pipe_pkg::reg_addr_t commit_dest;
    alu_pipe_pkg::data_t     commit_data;

    // stimulus rows and the commit each one should produce
    string                   row_name [NUM_ROWS];
    alu_pipe_pkg::op_t       row_op   [NUM_ROWS];
    alu_pipe_pkg::reg_addr_t row_rd   [NUM_ROWS];
    alu_pipe_pkg::reg_addr_t row_rs1  [NUM_ROWS];
    alu_pipe_pkg::reg_addr_t row_rs2  [NUM_ROWS];
    alu_pipe_pkg::data_t     row_imm  [NUM_ROWS];
    alu_pipe_pkg::reg_addr_t exp_dest [NUM_ROWS];
    alu_pipe_pkg::data_t     exp_data [NUM_ROWS];

    int commit_count = 0;

    clock_gen u_clock_gen (
        .clk_o    (clk),
        .locked_o (locked)
    );

    alu_pipe_top alu_pipe_top_i (
        .clk_i          (clk),
        .locked_i       (locked),
        .instr_valid_i  (instr_valid),
        .instr_ready_o  (instr_ready),
        .instr_op_i     (instr_op),
        .instr_rd_i     (instr_rd),
        .instr_rs1_i    (instr_rs1),
        .instr_rs2_i    (instr_rs2),
        .instr_imm_i    (instr_imm),
        .commit_valid_o (commit_valid),
        .commit_ready_i (commit_ready),
        .commit_dest_o  (commit_dest),
        .commit_data_o  (commit_data)
    );

    bind alu_pipe_top alu_pipe_checker u_checker (
        .clk_i          (clk_i),
        .locked_i       (locked_i),
        .instr_ready_i  (instr_ready_o),
        .commit_valid_i (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_dest_i  (commit_dest_o),
        .commit_data_i  (commit_data_o)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic set_row(input int idx, input string name, input alu_pipe_pkg::op_t op,
                           input alu_pipe_pkg::reg_addr_t rd,
                           input alu_pipe_pkg::reg_addr_t rs1,
                           input alu_pipe_pkg::reg_addr_t rs2,
                           input alu_pipe_pkg::data_t imm);
        row_name[idx] = name;
        row_op[idx]   = op;
        row_rd[idx]   = rd;
        row_rs1[idx]  = rs1;
        row_rs2[idx]  = rs2;
        row_imm[idx]  = imm;
    endtask

    task automatic fill_table();
        // load every register first
        set_row(0, "li_r0", alu_pipe_pkg::OP_LI, 3'd0, 3'd0, 3'd0, 32'h0000_0011);
        set_row(1, "li_r1", alu_pipe_pkg::OP_LI, 3'd1, 3'd0, 3'd0, 32'h1234_5678);
        set_row(2, "li_r2", alu_pipe_pkg::OP_LI, 3'd2, 3'd0, 3'd0, 32'hFFFF_0000);
        set_row(3, "li_r3", alu_pipe_pkg::OP_LI, 3'd3, 3'd0, 3'd0, 32'h0F0F_0F0F);
        set_row(4, "li_r4", alu_pipe_pkg::OP_LI, 3'd4, 3'd0, 3'd0, 32'h8000_0001);
        set_row(5, "li_r5", alu_pipe_pkg::OP_LI, 3'd5, 3'd0, 3'd0, 32'h0000_00FF);
        set_row(6, "li_r6", alu_pipe_pkg::OP_LI, 3'd6, 3'd0, 3'd0, 32'hDEAD_BEEF);
        set_row(7, "li_r7", alu_pipe_pkg::OP_LI, 3'd7, 3'd0, 3'd0, 32'h0000_0003);
        set_row(8, "add_r0_r1_r2", alu_pipe_pkg::OP_ADD, 3'd0, 3'd1, 3'd2, 32'h0);
        set_row(9, "sub_r3_r4_r5", alu_pipe_pkg::OP_SUB, 3'd3, 3'd4, 3'd5, 32'h0);
        set_row(10, "and_r6_r6_r2", alu_pipe_pkg::OP_AND, 3'd6, 3'd6, 3'd2, 32'h0);
        set_row(11, "or_r7_r3_r5", alu_pipe_pkg::OP_OR, 3'd7, 3'd3, 3'd5, 32'h0);
        set_row(12, "xor_r5_r1_r6", alu_pipe_pkg::OP_XOR, 3'd5, 3'd1, 3'd6, 32'h0);
        set_row(13, "sub_wrap_r4", alu_pipe_pkg::OP_SUB, 3'd4, 3'd7, 3'd1, 32'h0);
        // each row reads the dest of the one before
        set_row(14, "chain_add_r1", alu_pipe_pkg::OP_ADD, 3'd1, 3'd0, 3'd7, 32'h0);
        set_row(15, "chain_add_r2", alu_pipe_pkg::OP_ADD, 3'd2, 3'd1, 3'd1, 32'h0);
        set_row(16, "chain_sub_r3", alu_pipe_pkg::OP_SUB, 3'd3, 3'd2, 3'd0, 32'h0);
        set_row(17, "chain_xor_r4", alu_pipe_pkg::OP_XOR, 3'd4, 3'd3, 3'd2, 32'h0);
        set_row(18, "chain_or_r5", alu_pipe_pkg::OP_OR, 3'd5, 3'd4, 3'd1, 32'h0);
        set_row(19, "chain_and_r6", alu_pipe_pkg::OP_AND, 3'd6, 3'd5, 3'd3, 32'h0);
        set_row(20, "spare_op6_r7", 3'd6, 3'd7, 3'd7, 3'd7, 32'h0000_7777);  // acts as LI
        set_row(21, "add_r0_r7_r7", alu_pipe_pkg::OP_ADD, 3'd0, 3'd7, 3'd7, 32'h0);
        set_row(22, "li_r2_again", alu_pipe_pkg::OP_LI, 3'd2, 3'd0, 3'd0, 32'hA5A5_A5A5);
        set_row(23, "sub_r2_self", alu_pipe_pkg::OP_SUB, 3'd2, 3'd2, 3'd2, 32'h0);
    endtask

    function automatic alu_pipe_pkg::data_t expected_result(
        input alu_pipe_pkg::op_t op,
        input alu_pipe_pkg::data_t a,
        input alu_pipe_pkg::data_t b,
        input alu_pipe_pkg::data_t imm
    );
        case (op)
            alu_pipe_pkg::OP_ADD: return a + b;
            alu_pipe_pkg::OP_SUB: return a - b;
            alu_pipe_pkg::OP_AND: return a & b;
            alu_pipe_pkg::OP_OR:  return a | b;
            alu_pipe_pkg::OP_XOR: return a ^ b;
            default:              return imm;  // LI and the spare codes
        endcase
    endfunction

    // a register op whose sources name the dest of the row just accepted
    function automatic logic depends_on_previous(input int idx);
        logic reads_regs;
        if (idx == 0)
            return 1'b0;
        reads_regs = row_op[idx] inside {alu_pipe_pkg::OP_ADD, alu_pipe_pkg::OP_SUB,
                                         alu_pipe_pkg::OP_AND, alu_pipe_pkg::OP_OR,
                                         alu_pipe_pkg::OP_XOR};
        return reads_regs &&
               (row_rs1[idx] == row_rd[idx-1] || row_rs2[idx] == row_rd[idx-1]);
    endfunction

    // sequential model, one row at a time on its own register array
    task automatic build_expected();
        alu_pipe_pkg::data_t model [alu_pipe_pkg::NUM_REGS];
        alu_pipe_pkg::data_t res;
        for (int r = 0; r < alu_pipe_pkg::NUM_REGS; r++) begin
            model[r] = '0;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            res = expected_result(row_op[i], model[row_rs1[i]], model[row_rs2[i]], row_imm[i]);
            model[row_rd[i]] = res;
            exp_dest[i] = row_rd[i];
            exp_data[i] = res;
        end
    endtask

    initial begin : stimulus
        instr_valid <= 1'b0;
        instr_op    <= alu_pipe_pkg::OP_LI;
        instr_rd    <= '0;
        instr_rs1   <= '0;
        instr_rs2   <= '0;
        instr_imm   <= '0;
        fill_table();
        build_expected();

        wait (locked === 1'b1);
        @(negedge clk);
        assert (commit_valid === 1'b0 && instr_ready === 1'b1)
            else report_failure("DUT not idle and ready right after reset");

        @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            instr_valid <= 1'b1;
            instr_op    <= row_op[i];
            instr_rd    <= row_rd[i];
            instr_rs1   <= row_rs1[i];
            instr_rs2   <= row_rs2[i];
            instr_imm   <= row_imm[i];
            @(negedge clk);
            // previous row is still in flight, so this one must wait
            if (depends_on_previous(i)) begin
                assert (instr_ready === 1'b0)
                    else report_failure($sformatf("row %s was not stalled on its source",
                        row_name[i]));
            end
            while (!instr_ready) begin
                @(posedge clk);
                @(negedge clk);
            end
            @(posedge clk);
        end
        instr_valid <= 1'b0;

        wait (commit_count == NUM_ROWS);
        repeat (4) @(posedge clk);  // room for a stray extra commit to show
        $display("Test completed successfully");
        $finish;
    end

    initial begin : commit_pull
        commit_ready <= ($urandom(74) % 100) < 60;
        forever begin
            @(posedge clk);
            commit_ready <= ($urandom % 100) < 60;  // ready roughly 60% of cycles
        end
    end

    // both handshake signals are settled at the falling edge
    initial begin : commit_monitor
        wait (locked === 1'b1);
        forever begin
            @(negedge clk);
            if (commit_valid && commit_ready) begin
                assert (commit_count < NUM_ROWS)
                    else report_failure("commit arrived after every row had committed");
                assert (commit_dest == exp_dest[commit_count])
                    else report_failure($sformatf("Mismatch %s dest expected %0d actual %0d",
                        row_name[commit_count], exp_dest[commit_count], commit_dest));
                assert (commit_data == exp_data[commit_count])
                    else report_failure($sformatf("Mismatch %s data expected %h actual %h",
                        row_name[commit_count], exp_data[commit_count], commit_data));
                commit_count++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("timeout after %0d cycles, %0d of %0d rows committed",
            WATCHDOG_CYCLES, commit_count, NUM_ROWS));
    end

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// 40 ns clock, locked held low for the first two rising edges
module clock_gen (
    output logic clk_o,
    output logic locked_o
);

    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        locked_o <= 1'b0;  // PLL not locked yet
        repeat (2) @(posedge clk_o);
        locked_o <= 1'b1;
    end

endmodule

`default_nettype wire
